// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= mmio_tb
RTL_TOP    ?= mmio_top
FILELIST   ?= mmio_top.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Regression passed" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== include/mmio_consts.svh ====
`ifndef MMIO_CONSTS_SVH
`define MMIO_CONSTS_SVH

// memory map, all word addresses above the RAM window
`define MMIO_RAM_LIMIT      32'd2048        // first address outside RAM
`define MMIO_ADDR_TOUCH     32'h0000_0C00   // read: latest touch coordinate
`define MMIO_ADDR_SPI_CMD   32'h0000_0C04   // write: spi command and byte count
`define MMIO_ADDR_SPI_PARAM 32'h0000_0C08   // write: spi parameter, starts transfer

// system clocks per spi half period
`define SPI_CLK_DIV         2

`endif

// ==== mmio_top.f ====
+incdir+include
rtl/mmio_pkg.sv
rtl/touch_latch.sv
rtl/mmio_decoder.sv
rtl/spi_cmd_tx.sv
rtl/mmio_top.sv
tb/mmio_tb.sv

// ==== rtl/mmio_decoder.sv ====
`default_nettype none

`include "mmio_consts.svh"

// decodes handler requests against the map and sequences the target access
module mmio_decoder (
    input  wire logic             clk,
    input  wire logic             nRst,
    // memory handler
    input  mmio_pkg::mmio_req_t   req_i,
    output logic [31:0]           rdata_o,
    output logic                  busy_o,
    // word memory
    output mmio_pkg::mem_req_t    mem_req_o,
    input  wire logic [31:0]      mem_data_i,
    input  wire logic             mem_busy_i,
    // touch latch
    input  mmio_pkg::touch_t      touch_i,
    input  wire logic             touch_ready_i,
    output logic                  touch_consume_o,
    // spi transmitter
    output mmio_pkg::spi_cfg_t    spi_cfg_o,
    output logic                  spi_start_o,
    input  wire logic             spi_busy_i
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_WAIT,     // target chosen, waiting for it to be free
        S_MEMRD,    // memory data arrives this cycle
        S_DONE
    } state_t;

    typedef enum logic [2:0] {
        T_NONE,
        T_MEM_RD,
        T_MEM_WR,
        T_TOUCH,
        T_SPI_CMD,
        T_SPI_PARAM
    } target_t;

    state_t              state_q, state_d;
    target_t             tgt_q;
    mmio_pkg::mmio_req_t req_q;
    mmio_pkg::spi_word_u wword;

    logic        strobe_ok;
    logic        mem_rd, mem_wr;
    logic        launch;            // spi parameter accepted this cycle
    logic [31:0] rdata_q;
    logic [7:0]  cmd_q;
    logic [3:0]  cnt_q;
    logic [31:0] param_q;
    logic        start_q;

    // map lookup, done once when the request is taken
    function automatic target_t classify(input mmio_pkg::mmio_req_t r);
        target_t t;
        t = T_NONE;
        if (r.addr < `MMIO_RAM_LIMIT) begin
            t = r.read ? T_MEM_RD : T_MEM_WR;
        end else if (r.read && r.addr == `MMIO_ADDR_TOUCH) begin
            t = T_TOUCH;
        end else if (r.write && r.addr == `MMIO_ADDR_SPI_CMD) begin
            t = T_SPI_CMD;
        end else if (r.write && r.addr == `MMIO_ADDR_SPI_PARAM) begin
            t = T_SPI_PARAM;
        end
        return t;
    endfunction

    assign strobe_ok = req_i.read ^ req_i.write;   // both or neither is ignored
    assign wword     = req_q.wdata;

    always_comb begin
        state_d         = state_q;
        mem_rd          = 1'b0;
        mem_wr          = 1'b0;
        touch_consume_o = 1'b0;
        launch          = 1'b0;
        case (state_q)
            S_IDLE: begin
                if (strobe_ok) state_d = S_WAIT;
            end
            S_WAIT: begin
                case (tgt_q)
                    T_MEM_RD: begin
                        if (!mem_busy_i) begin   // else hold and retry
                            mem_rd  = 1'b1;
                            state_d = S_MEMRD;
                        end
                    end
                    T_MEM_WR: begin
                        if (!mem_busy_i) begin
                            mem_wr  = 1'b1;
                            state_d = S_DONE;
                        end
                    end
                    T_TOUCH: begin
                        if (touch_ready_i) begin
                            touch_consume_o = 1'b1;
                            state_d         = S_IDLE;
                        end
                    end
                    T_SPI_PARAM: begin
                        if (!spi_busy_i) begin
                            launch  = 1'b1;
                            state_d = S_DONE;
                        end
                    end
                    default: state_d = S_IDLE;   // spi command or unmapped
                endcase
            end
            S_MEMRD: state_d = S_IDLE;
            default: state_d = S_IDLE;
        endcase
    end

    // request copy, only looked at outside idle
    always_ff @(posedge clk) begin
        if (state_q == S_IDLE && strobe_ok) begin
            req_q <= req_i;
            tgt_q <= classify(req_i);
        end
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state_q <= S_IDLE;
            rdata_q <= '0;
            cmd_q   <= '0;
            cnt_q   <= '0;
            param_q <= '0;
            start_q <= 1'b0;
        end else begin
            state_q <= state_d;
            start_q <= launch;
            if (state_q == S_MEMRD) begin
                rdata_q <= mem_data_i;
            end else if (touch_consume_o) begin
                rdata_q <= touch_i;
            end
            // command and count stay put across parameter writes
            if (state_q == S_WAIT && tgt_q == T_SPI_CMD) begin
                cmd_q <= wword.cmd.cmd;
                cnt_q <= wword.cmd.count;
            end
            if (launch) param_q <= wword.param;
        end
    end

    assign busy_o  = (state_q != S_IDLE);
    assign rdata_o = rdata_q;

    always_comb begin
        mem_req_o.read  = mem_rd;
        mem_req_o.write = mem_wr;
        mem_req_o.addr  = req_q.addr;
        mem_req_o.data  = req_q.wdata;
    end

    always_comb begin
        spi_cfg_o.cmd   = cmd_q;
        spi_cfg_o.count = cnt_q;
        spi_cfg_o.param = param_q;
    end

    assign spi_start_o = start_q;

endmodule

`default_nettype wire

// ==== rtl/mmio_pkg.sv ====
`default_nettype none

package mmio_pkg;

    // single word request from the memory handler
    typedef struct packed {
        logic        read;
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
    } mmio_req_t;

    // single beat request to the word memory
    typedef struct packed {
        logic        read;    // one cycle pulse
        logic        write;   // one cycle pulse
        logic [31:0] addr;
        logic [31:0] data;
    } mem_req_t;

    // what the spi transmitter needs for one frame
    typedef struct packed {
        logic [7:0]  cmd;
        logic [3:0]  count;   // parameter bytes, clamped to 4 by the transmitter
        logic [31:0] param;
    } spi_cfg_t;

    // touch coordinate as delivered by the i2c front end
    typedef struct packed {
        logic [15:0] x;
        logic [15:0] y;
    } touch_t;

    // handler write data seen as a command word or as a raw parameter
    typedef union packed {
        struct packed {
            logic [19:0] rsvd;
            logic [3:0]  count;
            logic [7:0]  cmd;
        } cmd;
        logic [31:0] param;
    } spi_word_u;

endpackage

`default_nettype wire

// ==== rtl/mmio_top.sv ====
`default_nettype none

// mmio block: touch input, address decoder and spi command output
module mmio_top (
    input  wire logic           clk,
    input  wire logic           nRst,
    // memory handler
    input  mmio_pkg::mmio_req_t req_i,
    output logic [31:0]         rdata_o,
    output logic                busy_o,
    // word memory bus
    output mmio_pkg::mem_req_t  mem_req_o,
    input  wire logic [31:0]    mem_data_i,
    input  wire logic           mem_busy_i,
    // i2c touch front end
    input  mmio_pkg::touch_t    i2c_xy_i,
    input  wire logic           i2c_done_i,
    output logic                touch_ready_o,
    // display spi pins
    output logic                spi_sclk_o,
    output logic                spi_mosi_o,
    output logic                spi_cs_n_o
);

    mmio_pkg::touch_t   touch_xy;
    logic               touch_ready;
    logic               touch_consume;
    mmio_pkg::spi_cfg_t spi_cfg;
    logic               spi_start;
    logic               spi_busy;

    touch_latch u_touch (
        .clk        (clk),
        .nRst       (nRst),
        .i2c_done_i (i2c_done_i),
        .i2c_xy_i   (i2c_xy_i),
        .consume_i  (touch_consume),
        .xy_o       (touch_xy),
        .ready_o    (touch_ready)
    );

    mmio_decoder u_dec (
        .clk             (clk),
        .nRst            (nRst),
        .req_i           (req_i),
        .rdata_o         (rdata_o),
        .busy_o          (busy_o),
        .mem_req_o       (mem_req_o),
        .mem_data_i      (mem_data_i),
        .mem_busy_i      (mem_busy_i),
        .touch_i         (touch_xy),
        .touch_ready_i   (touch_ready),
        .touch_consume_o (touch_consume),
        .spi_cfg_o       (spi_cfg),
        .spi_start_o     (spi_start),
        .spi_busy_i      (spi_busy)
    );

    spi_cmd_tx u_spi (
        .clk        (clk),
        .nRst       (nRst),
        .start_i    (spi_start),
        .cfg_i      (spi_cfg),
        .busy_o     (spi_busy),
        .spi_sclk_o (spi_sclk_o),
        .spi_mosi_o (spi_mosi_o),
        .spi_cs_n_o (spi_cs_n_o)
    );

    assign touch_ready_o = touch_ready;   // handler polls this

endmodule

`default_nettype wire

// ==== rtl/spi_cmd_tx.sv ====
`default_nettype none

`include "mmio_consts.svh"

// sends one command byte and up to four parameter bytes, mode 0, msb first
module spi_cmd_tx (
    input  wire logic          clk,
    input  wire logic          nRst,
    input  wire logic          start_i,
    input  mmio_pkg::spi_cfg_t cfg_i,
    output logic               busy_o,
    output logic               spi_sclk_o,
    output logic               spi_mosi_o,
    output logic               spi_cs_n_o
);

    localparam int DIV_W = $clog2(`SPI_CLK_DIV + 1);
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`SPI_CLK_DIV - 1);

    logic [DIV_W-1:0] div_cnt;
    logic [2:0]       bit_cnt;      // bit within the current byte
    logic [2:0]       byte_cnt;     // parameter bytes still to send
    logic [39:0]      shreg;        // command in the top byte
    logic             sclk_q;
    logic             cs_n_q;
    logic             tick;         // half period elapsed

    assign tick = !cs_n_q && (div_cnt == DIV_LAST);

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            div_cnt  <= '0;
            bit_cnt  <= '0;
            byte_cnt <= '0;
            shreg    <= '0;
            sclk_q   <= 1'b0;
            cs_n_q   <= 1'b1;
        end else if (cs_n_q) begin
            if (start_i) begin
                shreg    <= {cfg_i.cmd, cfg_i.param};
                byte_cnt <= (cfg_i.count > 4'd4) ? 3'd4 : cfg_i.count[2:0];
                bit_cnt  <= '0;
                div_cnt  <= '0;
                cs_n_q   <= 1'b0;   // first bit is already on mosi
            end
        end else if (tick) begin
            div_cnt <= '0;
            if (!sclk_q) begin
                sclk_q <= 1'b1;     // receiver samples here
            end else begin
                sclk_q  <= 1'b0;    // next bit goes out on the fall
                shreg   <= {shreg[38:0], 1'b0};
                bit_cnt <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7) begin
                    if (byte_cnt == 3'd0) begin
                        cs_n_q <= 1'b1; // frame done
                    end else begin
                        byte_cnt <= byte_cnt - 3'd1;
                    end
                end
            end
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign busy_o     = ~cs_n_q;
    assign spi_sclk_o = sclk_q;
    assign spi_mosi_o = shreg[39];
    assign spi_cs_n_o = cs_n_q;

endmodule

`default_nettype wire

// ==== rtl/touch_latch.sv ====
`default_nettype none

// holds the last coordinate from the i2c front end until the handler reads it
module touch_latch (
    input  wire logic            clk,
    input  wire logic            nRst,
    input  wire logic            i2c_done_i,   // one cycle, coordinate valid
    input  mmio_pkg::touch_t     i2c_xy_i,
    input  wire logic            consume_i,    // decoder took the coordinate
    output mmio_pkg::touch_t     xy_o,
    output logic                 ready_o
);

    mmio_pkg::touch_t xy_q;
    logic             ready_q;

    // coordinate register, only meaningful while ready is set
    always_ff @(posedge clk) begin
        if (i2c_done_i) begin
            xy_q <= i2c_xy_i;
        end
    end

    // a fresh sample beats a consume in the same cycle
    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            ready_q <= 1'b0;
        end else if (i2c_done_i) begin
            ready_q <= 1'b1;
        end else if (consume_i) begin
            ready_q <= 1'b0;
        end
    end

    assign xy_o    = xy_q;
    assign ready_o = ready_q;

endmodule

`default_nettype wire

// ==== tb/mmio_tb.sv ====
`default_nettype none

`include "mmio_consts.svh"

module mmio_tb;

    localparam int MAX_VEC    = 64;
    localparam int CYCLE      = 10;
    localparam int VEC_CYCLES = 40 * 2 * `SPI_CLK_DIV + 300;   // longest frame plus margin

    logic                clk;
    logic                nRst;
    mmio_pkg::mmio_req_t req_i;
    logic [31:0]         rdata_o;
    logic                busy_o;
    mmio_pkg::mem_req_t  mem_req_o;
    logic [31:0]         mem_data_i;
    logic                mem_busy_i;
    mmio_pkg::touch_t    i2c_xy_i;
    logic                i2c_done_i;
    logic                touch_ready_o;
    logic                spi_sclk_o;
    logic                spi_mosi_o;
    logic                spi_cs_n_o;

    logic [39:0] vec [0:5*MAX_VEC-1];   // five words per test line
    logic [31:0] mem [0:2047];
    integer      seed = 32'h869e_87ff;
    logic        bp_en;
    logic        bp_q;
    logic        rd_pend;
    logic [10:0] rd_addr;
    int          mem_pulses;
    int          err_cnt;
    int          cur_test;
    int          nvec;
    logic        loaded;
    logic [39:0] mon_frame;
    int          mon_bits;
    logic [39:0] frame_q[$];
    int          bits_q[$];

    mmio_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #(CYCLE/2) clk = ~clk;
    end

    // memory bus taken as the DUT commits it at the clock edge
    always @(posedge clk) begin
        if (mem_req_o.read || mem_req_o.write) begin
            mem_pulses++;
            if (mem_busy_i) begin
                $display("test %0d: memory pulse issued while mem_busy_i was high", cur_test);
                err_cnt++;
            end
        end
        if (mem_req_o.write) mem[mem_req_o.addr[10:0]] <= mem_req_o.data;
        rd_pend <= mem_req_o.read;
        rd_addr <= mem_req_o.addr[10:0];
        bp_q    <= bp_en;
    end

    always @(negedge clk) begin
        mem_data_i = rd_pend ? mem[rd_addr] : 32'hdead_beef;   // junk outside the data cycle
        mem_busy_i = bp_q && (($random(seed) & 3) != 0);
    end

    // spi receiver, mode 0
    always @(posedge spi_sclk_o) begin
        if (!spi_cs_n_o) begin
            mon_frame = {mon_frame[38:0], spi_mosi_o};
            mon_bits++;
        end
    end

    always @(posedge spi_cs_n_o) begin
        if (mon_bits != 0) begin
            frame_q.push_back(mon_frame);
            bits_q.push_back(mon_bits);
        end
        mon_frame = '0;
        mon_bits  = 0;
    end

    task automatic report_mismatch(input string name, input logic [39:0] exp,
                                   input logic [39:0] got);
        $display("ERROR test %0d: %s expected %h got %h", cur_test, name, exp, got);
        err_cnt++;
    endtask

    task automatic strobe(input logic rd, input logic wr, input logic [31:0] addr,
                          input logic [31:0] data);
        req_i = {rd, wr, addr, data};
        @(negedge clk);
        req_i.read  = 1'b0;
        req_i.write = 1'b0;
    endtask

    // returns at the negedge of the cycle where busy_o fell
    task automatic count_busy(output int n);
        n = 0;
        while (busy_o) begin
            n++;
            @(negedge clk);
        end
    endtask

    task automatic pulse_done(input logic [31:0] xy);
        i2c_xy_i   = xy;
        i2c_done_i = 1'b1;
        @(negedge clk);
        i2c_done_i = 1'b0;
    endtask

    task automatic access(input logic rd, input logic [31:0] addr, input logic [31:0] data,
                          input logic [39:0] exp, input int busy_exp);
        int n;
        int p0;
        int p_exp;
        p0    = mem_pulses;
        p_exp = (addr < `MMIO_RAM_LIMIT) ? 1 : 0;   // one pulse for ram, none elsewhere
        strobe(rd, !rd, addr, data);
        count_busy(n);
        if (busy_exp != 255 && n != busy_exp)
            report_mismatch("busy_o cycles", busy_exp, n);
        if (rd && rdata_o !== exp[31:0])
            report_mismatch("rdata_o", exp, rdata_o);
        if (mem_pulses - p0 != p_exp)
            report_mismatch("mem_req_o pulses", p_exp, mem_pulses - p0);
    endtask

    task automatic touch_read(input logic [31:0] addr, input logic [31:0] xy,
                              input logic [39:0] exp, input int delay);
        int n;
        if (delay == 0) begin   // coordinate already waiting
            pulse_done(xy);
            if (!touch_ready_o) begin
                $display("test %0d: touch_ready_o did not rise after the done pulse", cur_test);
                err_cnt++;
            end
        end
        strobe(1'b1, 1'b0, addr, 32'h0);
        repeat (delay) begin
            if (!busy_o) begin
                $display("test %0d: touch read ended before any coordinate arrived", cur_test);
                err_cnt++;
            end
            @(negedge clk);
        end
        if (delay != 0) pulse_done(xy);
        count_busy(n);
        if (delay == 0 && n != 1)
            report_mismatch("busy_o cycles", 1, n);
        if (rdata_o !== exp[31:0])
            report_mismatch("rdata_o", exp, rdata_o);
        if (touch_ready_o !== 1'b0)
            report_mismatch("touch_ready_o", 0, touch_ready_o);
    endtask

    task automatic check_frame(input logic [39:0] exp, input int bits);
        logic [39:0] f;
        int          n;
        while (frame_q.size() == 0) @(negedge clk);
        f = frame_q.pop_front();
        n = bits_q.pop_front();
        if (n != bits)
            report_mismatch("spi frame bits", bits, n);
        if (f !== exp)
            report_mismatch("spi_mosi_o frame", exp, f);
    endtask

    // both strobe bits set, nothing may happen
    task automatic malformed(input logic [31:0] addr, input logic [31:0] data,
                             input int busy_exp);
        int n;
        int p0;
        n  = 0;
        p0 = mem_pulses;
        strobe(1'b1, 1'b1, addr, data);
        repeat (4) begin
            if (busy_o) n++;
            @(negedge clk);
        end
        if (n != busy_exp)
            report_mismatch("busy_o cycles", busy_exp, n);
        if (mem_pulses != p0)
            report_mismatch("mem_req_o pulses", 0, mem_pulses - p0);
    endtask

    initial begin
        int          pass_cnt;
        int          fail_cnt;
        int          e0;
        int          p0;
        int          cnt;
        logic [7:0]  op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [39:0] exp;
        nRst       = 1'b0;
        req_i      = '0;
        mem_data_i = '0;
        mem_busy_i = 1'b0;
        i2c_xy_i   = '0;
        i2c_done_i = 1'b0;
        bp_en      = 1'b0;
        mon_frame  = '0;
        pass_cnt   = 0;
        fail_cnt   = 0;
        loaded     = 1'b0;
        for (int i = 0; i < 2048; i++)
            mem[i] = 32'hc0de_0000 | i;
        $readmemh("tb/mmio_testdata.txt", vec);
        nvec = 0;
        while (nvec < MAX_VEC && vec[5*nvec][7:0] != 8'h00) nvec++;   // op 00 ends the list
        loaded = 1'b1;
        repeat (10) @(negedge clk);
        nRst = 1'b1;
        @(negedge clk);
        for (int t = 0; t < nvec; t++) begin
            op       = vec[5*t][7:0];
            addr     = vec[5*t+1][31:0];
            data     = vec[5*t+2][31:0];
            exp      = vec[5*t+3];
            cnt      = vec[5*t+4][7:0];
            cur_test = t;
            e0       = err_cnt;
            bp_en    = op[4];
            case (op[3:0])
                4'h1: access(1'b0, addr, data, exp, cnt);
                4'h2: access(1'b1, addr, data, exp, cnt);
                4'h3: touch_read(addr, data, exp, cnt);
                4'h4: check_frame(exp, cnt);
                4'h5: malformed(addr, data, cnt);
                default: begin
                    $display("test %0d: unknown operation code %h", t, op);
                    err_cnt++;
                end
            endcase
            bp_en = 1'b0;
            if (err_cnt == e0) begin
                pass_cnt++;
                $display("test %0d op %h addr %h: pass", t, op, addr);
            end else begin
                fail_cnt++;
                $display("test %0d op %h addr %h: fail", t, op, addr);
            end
        end
        p0 = mem_pulses;
        repeat (40 * 2 * `SPI_CLK_DIV + 10) @(negedge clk);   // room for a stray frame
        if (frame_q.size() != 0 || !spi_cs_n_o || mem_pulses != p0) begin
            $display("activity after the last test: an spi frame or memory pulse nobody asked for");
            fail_cnt++;
        end
        $display("%0d tests passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        wait (loaded);
        #((nvec + 2) * VEC_CYCLES * CYCLE);
        $display("timeout: test %0d never finished", cur_test);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/mmio_testdata.txt ====
// op address data expected count, all hex
// op 01 write, 02 read, 03 touch read, 04 spi frame, 05 both strobe bits, +10 memory back-pressure
// count is busy cycles (ff unchecked), cycles before the done pulse for 03, frame bits for 04
01 00000010 cafe0001 0000000000 02
02 00000010 00000000 00cafe0001 02
02 00000123 00000000 00c0de0123 02
01 000007ff 12345678 0000000000 02
02 000007ff 00000000 0012345678 02
11 00000020 a5a5a5a5 0000000000 ff
11 00000021 5a5a5a5a 0000000000 ff
12 00000020 00000000 00a5a5a5a5 ff
12 00000021 00000000 005a5a5a5a ff
12 00000300 00000000 00c0de0300 ff
03 00000c00 00640032 0000640032 05
03 00000c00 01f400c8 0001f400c8 03
03 00000c00 00010002 0000010002 00
01 00000c04 0000042a 0000000000 01
01 00000c08 11223344 0000000000 02
04 00000000 00000000 2a11223344 28
01 00000c04 000000b0 0000000000 01
01 00000c08 deadbeef 0000000000 02
04 00000000 00000000 00000000b0 08
01 00000c04 000006c5 0000000000 01
01 00000c08 a1b2c3d4 0000000000 02
04 00000000 00000000 c5a1b2c3d4 28
01 00000c04 0000023c 0000000000 01
01 00000c08 55667788 0000000000 02
01 00000c08 99aabbcc 0000000000 ff
04 00000000 00000000 00003c5566 18
04 00000000 00000000 00003c99aa 18
02 00000010 00000000 00cafe0001 02
02 00001000 00000000 00cafe0001 01
02 00000c04 00000000 00cafe0001 01
01 00000c00 77777777 0000000000 01
01 00004000 00000000 0000000000 01
05 00000010 ffffffff 0000000000 00
02 00000010 00000000 00cafe0001 02
00 00000000 00000000 0000000000 00
